/* verilog/soc_pkg.sv */
// ----------------------------------------
// SoC harness package
// Bus widths, bus types, the decode region
// enumeration and the memory map shared by
// the decoder and all targets
// ----------------------------------------
`default_nettype none

package soc_pkg;

    // ----------------------------------------
    // Bus widths and types
    // ----------------------------------------
    localparam int unsigned AddrWidth = 32;
    localparam int unsigned DataWidth = 64;
    localparam int unsigned StrbWidth = DataWidth / 8;

    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [DataWidth-1:0] data_t;
    typedef logic [StrbWidth-1:0] strb_t;

    // Decode result, one per target plus no-match
    typedef enum logic [1:0] {
        RegionRom   = 2'd0,
        RegionClint = 2'd1,
        RegionDram  = 2'd2,
        RegionNone  = 2'd3
    } region_e;

    // ----------------------------------------
    // Address map
    // ----------------------------------------
    localparam addr_t RomBase   = 32'h0001_0000;
    localparam addr_t RomLength = 32'h0001_0000;

    localparam addr_t ClintBase   = 32'h0200_0000;
    localparam addr_t ClintLength = 32'h0000_C000;

    // DRAM length follows from the configured depth
    localparam addr_t DramBase = 32'h8000_0000;

    // CLINT register offsets from ClintBase
    localparam addr_t ClintMsipOffset     = 32'h0000_0000;
    localparam addr_t ClintMtimecmpOffset = 32'h0000_4000;
    localparam addr_t ClintMtimeOffset    = 32'h0000_BFF8;

    // Boot ROM contents rule
    localparam int unsigned RomWords = 16;
    localparam logic [31:0] RomTag   = 32'hB007_0000;

endpackage

`default_nettype wire

/* verilog/addr_decoder.sv */
// ----------------------------------------
// Address decoder
// Steers each request to ROM, CLINT or DRAM,
// then returns the response one cycle later
// with the read data of the decoded target
// ----------------------------------------
`default_nettype none

module addr_decoder #(
    parameter int unsigned NumWords = 1024
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            req_i,
    input  soc_pkg::addr_t  addr_i,
    output logic            rom_sel_o,
    output logic            clint_sel_o,
    output logic            dram_sel_o,
    input  soc_pkg::data_t  rom_rdata_i,
    input  soc_pkg::data_t  clint_rdata_i,
    input  soc_pkg::data_t  dram_rdata_i,
    output logic            rvalid_o,
    output soc_pkg::data_t  rdata_o,
    output logic            err_o
);

    localparam soc_pkg::addr_t DramLength = soc_pkg::addr_t'(NumWords * 8);

    soc_pkg::region_e region_d;
    soc_pkg::region_e region_q;
    logic             valid_q;

    // Half-open range check, written without base plus length overflow
    function automatic logic in_range(soc_pkg::addr_t a, soc_pkg::addr_t base,
                                      soc_pkg::addr_t len);
        return (a >= base) && ((a - base) < len);
    endfunction

    // ----------------------------------------
    // Request side
    // ----------------------------------------
    always_comb begin
        region_d = soc_pkg::RegionNone;
        if (in_range(addr_i, soc_pkg::RomBase, soc_pkg::RomLength)) begin
            region_d = soc_pkg::RegionRom;
        end else if (in_range(addr_i, soc_pkg::ClintBase, soc_pkg::ClintLength)) begin
            region_d = soc_pkg::RegionClint;
        end else if (in_range(addr_i, soc_pkg::DramBase, DramLength)) begin
            region_d = soc_pkg::RegionDram;
        end
    end

    assign rom_sel_o   = req_i && (region_d == soc_pkg::RegionRom);
    assign clint_sel_o = req_i && (region_d == soc_pkg::RegionClint);
    assign dram_sel_o  = req_i && (region_d == soc_pkg::RegionDram);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q  <= 1'b0;
            region_q <= soc_pkg::RegionNone;
        end else begin
            valid_q  <= req_i;
            region_q <= req_i ? region_d : soc_pkg::RegionNone;
        end
    end

    // ----------------------------------------
    // Response side
    // ----------------------------------------
    always_comb begin
        case (region_q)
            soc_pkg::RegionRom:   rdata_o = rom_rdata_i;
            soc_pkg::RegionClint: rdata_o = clint_rdata_i;
            soc_pkg::RegionDram:  rdata_o = dram_rdata_i;
            default:              rdata_o = '0;
        endcase
    end

    assign rvalid_o = valid_q;
    assign err_o    = valid_q && (region_q == soc_pkg::RegionNone);

endmodule

`default_nettype wire

/* verilog/boot_rom.sv */
// ----------------------------------------
// Boot ROM
// Read-only words built from a fixed rule,
// read with one cycle of latency
// ----------------------------------------
`default_nettype none

module boot_rom (
    input  logic            clk_i,
    input  logic            sel_i,
    input  soc_pkg::addr_t  addr_i,
    output soc_pkg::data_t  rdata_o
);

    localparam int unsigned IdxWidth = $clog2(soc_pkg::RomWords);

    soc_pkg::addr_t       offset;
    logic [IdxWidth-1:0]  word_idx;
    soc_pkg::data_t       rdata_q;

    // Upper half is the tag plus the index, lower half its inverse
    function automatic soc_pkg::data_t rom_word(logic [IdxWidth-1:0] n);
        logic [31:0] upper;
        upper = soc_pkg::RomTag + 32'(n);
        return {upper, ~upper};
    endfunction

    assign offset   = addr_i - soc_pkg::RomBase;
    assign word_idx = offset[3 +: IdxWidth];

    // Idle cycles leave zero behind for the response mux
    always_ff @(posedge clk_i) begin
        rdata_q <= sel_i ? rom_word(word_idx) : '0;
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* verilog/dram_mem.sv */
// ----------------------------------------
// Main memory
// Single-port RAM of 64-bit words with byte
// enables and a registered read port
// ----------------------------------------
`default_nettype none

module dram_mem #(
    parameter int unsigned NumWords = 1024
) (
    input  logic            clk_i,
    input  logic            sel_i,
    input  logic            we_i,
    input  soc_pkg::addr_t  addr_i,
    input  soc_pkg::strb_t  be_i,
    input  soc_pkg::data_t  wdata_i,
    output soc_pkg::data_t  rdata_o
);

    localparam int unsigned IdxWidth = $clog2(NumWords);

    soc_pkg::data_t       mem [NumWords];
    soc_pkg::addr_t       offset;
    logic [IdxWidth-1:0]  word_idx;
    soc_pkg::data_t       rdata_q;

    // Word index wraps at the memory depth
    assign offset   = addr_i - soc_pkg::DramBase;
    assign word_idx = offset[3 +: IdxWidth];

    always_ff @(posedge clk_i) begin
        if (sel_i && we_i) begin
            for (int b = 0; b < soc_pkg::StrbWidth; b++) begin
                if (be_i[b]) begin
                    mem[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    // Writes and idle cycles return zero
    always_ff @(posedge clk_i) begin
        rdata_q <= (sel_i && !we_i) ? mem[word_idx] : '0;
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* verilog/clint_timer.sv */
// ----------------------------------------
// Core-local interruptor
// Real-time counter clocked by rtc edges,
// compare register for the timer interrupt
// and a software interrupt bit
// ----------------------------------------
`default_nettype none

module clint_timer (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            rtc_i,
    input  logic            sel_i,
    input  logic            we_i,
    input  soc_pkg::addr_t  addr_i,
    input  soc_pkg::strb_t  be_i,
    input  soc_pkg::data_t  wdata_i,
    output soc_pkg::data_t  rdata_o,
    output logic            timer_irq_o,
    output logic            ipi_o
);

    soc_pkg::addr_t  offset;
    soc_pkg::addr_t  reg_off;

    logic [1:0]      rtc_sync_q;
    logic            rtc_prev_q;
    logic            rtc_tick;

    soc_pkg::data_t  mtime_d, mtime_q;
    soc_pkg::data_t  mtimecmp_d, mtimecmp_q;
    logic            msip_d, msip_q;
    logic            timer_irq_q;
    logic            ipi_q;

    soc_pkg::data_t  read_val;
    soc_pkg::data_t  rdata_q;

    // Byte-wise merge of write data into a register value
    function automatic soc_pkg::data_t merge(soc_pkg::data_t old, soc_pkg::data_t wd,
                                             soc_pkg::strb_t be);
        soc_pkg::data_t res;
        res = old;
        for (int b = 0; b < soc_pkg::StrbWidth; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = wd[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // Register offset within the CLINT window, word aligned
    assign offset  = addr_i - soc_pkg::ClintBase;
    assign reg_off = {offset[soc_pkg::AddrWidth-1:3], 3'b000};

    // ----------------------------------------
    // RTC synchronizer and edge detect
    // ----------------------------------------
    assign rtc_tick = rtc_sync_q[1] && !rtc_prev_q;

    // ----------------------------------------
    // Register next state
    // ----------------------------------------
    always_comb begin
        mtime_d    = rtc_tick ? (mtime_q + soc_pkg::data_t'(1)) : mtime_q;
        mtimecmp_d = mtimecmp_q;
        msip_d     = msip_q;
        // A bus write to mtime overrides a tick in the same cycle
        if (sel_i && we_i) begin
            case (reg_off)
                soc_pkg::ClintMsipOffset: begin
                    if (be_i[0]) begin
                        msip_d = wdata_i[0];
                    end
                end
                soc_pkg::ClintMtimecmpOffset: mtimecmp_d = merge(mtimecmp_q, wdata_i, be_i);
                soc_pkg::ClintMtimeOffset:    mtime_d    = merge(mtime_d, wdata_i, be_i);
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rtc_sync_q  <= 2'b00;
            rtc_prev_q  <= 1'b0;
            mtime_q     <= '0;
            mtimecmp_q  <= '1;
            msip_q      <= 1'b0;
            timer_irq_q <= 1'b0;
            ipi_q       <= 1'b0;
        end else begin
            rtc_sync_q  <= {rtc_sync_q[0], rtc_i};
            rtc_prev_q  <= rtc_sync_q[1];
            mtime_q     <= mtime_d;
            mtimecmp_q  <= mtimecmp_d;
            msip_q      <= msip_d;
            timer_irq_q <= (mtime_q >= mtimecmp_q);
            ipi_q       <= msip_q;
        end
    end

    // ----------------------------------------
    // Read path
    // ----------------------------------------
    always_comb begin
        case (reg_off)
            soc_pkg::ClintMsipOffset:     read_val = {{(soc_pkg::DataWidth-1){1'b0}}, msip_q};
            soc_pkg::ClintMtimecmpOffset: read_val = mtimecmp_q;
            soc_pkg::ClintMtimeOffset:    read_val = mtime_q;
            default:                      read_val = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        rdata_q <= (sel_i && !we_i) ? read_val : '0;
    end

    assign rdata_o     = rdata_q;
    assign timer_irq_o = timer_irq_q;
    assign ipi_o       = ipi_q;

endmodule

`default_nettype wire

/* verilog/soc_harness.sv */
// ----------------------------------------
// SoC test harness
// Memory-mapped platform behind a plain
// request bus: decoder, boot ROM, main
// memory and core-local interruptor
// ----------------------------------------
`default_nettype none

module soc_harness #(
    parameter int unsigned NumWords = 1024
) (
    input  logic            clk_i,
    input  logic            rtc_i,
    input  logic            rst_n_i,
    input  logic            req_i,
    input  logic            we_i,
    input  soc_pkg::addr_t  addr_i,
    input  soc_pkg::strb_t  be_i,
    input  soc_pkg::data_t  wdata_i,
    output logic            rvalid_o,
    output soc_pkg::data_t  rdata_o,
    output logic            err_o,
    output logic            timer_irq_o,
    output logic            ipi_o
);

    logic            rom_sel;
    logic            clint_sel;
    logic            dram_sel;
    soc_pkg::data_t  rom_rdata;
    soc_pkg::data_t  clint_rdata;
    soc_pkg::data_t  dram_rdata;

    // ----------------------------------------
    // Decoder
    // ----------------------------------------
    addr_decoder #(
        .NumWords      ( NumWords    )
    ) i_addr_decoder (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .req_i         ( req_i       ),
        .addr_i        ( addr_i      ),
        .rom_sel_o     ( rom_sel     ),
        .clint_sel_o   ( clint_sel   ),
        .dram_sel_o    ( dram_sel    ),
        .rom_rdata_i   ( rom_rdata   ),
        .clint_rdata_i ( clint_rdata ),
        .dram_rdata_i  ( dram_rdata  ),
        .rvalid_o      ( rvalid_o    ),
        .rdata_o       ( rdata_o     ),
        .err_o         ( err_o       )
    );

    // ----------------------------------------
    // Targets
    // ----------------------------------------
    // ROM only sees reads, so a ROM write answers with zero data
    boot_rom i_boot_rom (
        .clk_i   ( clk_i             ),
        .sel_i   ( rom_sel & ~we_i   ),
        .addr_i  ( addr_i            ),
        .rdata_o ( rom_rdata         )
    );

    dram_mem #(
        .NumWords ( NumWords   )
    ) i_dram_mem (
        .clk_i    ( clk_i      ),
        .sel_i    ( dram_sel   ),
        .we_i     ( we_i       ),
        .addr_i   ( addr_i     ),
        .be_i     ( be_i       ),
        .wdata_i  ( wdata_i    ),
        .rdata_o  ( dram_rdata )
    );

    clint_timer i_clint_timer (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .rtc_i       ( rtc_i       ),
        .sel_i       ( clint_sel   ),
        .we_i        ( we_i        ),
        .addr_i      ( addr_i      ),
        .be_i        ( be_i        ),
        .wdata_i     ( wdata_i     ),
        .rdata_o     ( clint_rdata ),
        .timer_irq_o ( timer_irq_o ),
        .ipi_o       ( ipi_o       )
    );

endmodule

`default_nettype wire

/* verif/tb_soc_harness.sv */
// ----------------------------------------
// SoC harness testbench
// Drives the request bus, predicts every
// response with a reference model and
// checks data, errors and interrupts
// ----------------------------------------
`default_nettype none

module tb_soc_harness;

    localparam int unsigned NumWords  = 1024;
    localparam int unsigned ClkPeriod = 20;
    localparam int unsigned WinWords  = 32;
    localparam int unsigned MixReqs   = 64;
    localparam int unsigned PreTicks  = 2;
    localparam int unsigned TickCount = 5;

    // Request count of each test in test order
    localparam int unsigned RomReqs     = soc_pkg::RomWords + 2;
    localparam int unsigned DramReqs    = 2 * WinWords + MixReqs;
    localparam int unsigned DecodeReqs  = 9;
    localparam int unsigned TimerReqs   = 2 + 4;
    localparam int unsigned NumRequests = RomReqs + DramReqs + DecodeReqs + TimerReqs;
    localparam int unsigned WatchdogCycles = NumRequests * 20 + 2000;

    logic            clk;
    logic            rst_n;
    logic            rtc;
    logic            req;
    logic            we;
    soc_pkg::addr_t  addr;
    soc_pkg::strb_t  be;
    soc_pkg::data_t  wdata;
    logic            rvalid;
    soc_pkg::data_t  rdata;
    logic            err;
    logic            timer_irq;
    logic            ipi;

    // Reference model state
    soc_pkg::data_t  ref_mem [NumWords];
    soc_pkg::data_t  ref_mtime;
    soc_pkg::data_t  ref_mtimecmp;
    logic            ref_msip;

    // Outstanding responses in issue order
    soc_pkg::data_t  exp_data_q[$];
    logic            exp_err_q[$];
    int unsigned     exp_due_q[$];
    string           exp_name_q[$];

    int unsigned     cyc;
    int unsigned     checks;
    int unsigned     errors;
    int unsigned     tests;
    int unsigned     failed_tests;
    int unsigned     test_start_errors;

    soc_harness #(
        .NumWords    ( NumWords  )
    ) uut (
        .clk_i       ( clk       ),
        .rtc_i       ( rtc       ),
        .rst_n_i     ( rst_n     ),
        .req_i       ( req       ),
        .we_i        ( we        ),
        .addr_i      ( addr      ),
        .be_i        ( be        ),
        .wdata_i     ( wdata     ),
        .rvalid_o    ( rvalid    ),
        .rdata_o     ( rdata     ),
        .err_o       ( err       ),
        .timer_irq_o ( timer_irq ),
        .ipi_o       ( ipi       )
    );

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic in_window(soc_pkg::addr_t a, soc_pkg::addr_t base,
                                       soc_pkg::addr_t len);
        return ({1'b0, a} >= {1'b0, base}) && ({1'b0, a} < ({1'b0, base} + {1'b0, len}));
    endfunction

    function automatic soc_pkg::data_t apply_bytes(soc_pkg::data_t old, soc_pkg::data_t wd,
                                                   soc_pkg::strb_t en);
        soc_pkg::data_t mask;
        for (int b = 0; b < soc_pkg::StrbWidth; b++) begin
            mask[b*8 +: 8] = {8{en[b]}};
        end
        return (old & ~mask) | (wd & mask);
    endfunction

    // Predicts one response and updates the model on writes
    function automatic soc_pkg::data_t ref_access(input logic is_wr, input soc_pkg::addr_t a,
            input soc_pkg::strb_t en, input soc_pkg::data_t wd, output logic exp_e);
        soc_pkg::addr_t  off;
        int unsigned     n;
        logic [31:0]     upper;
        soc_pkg::data_t  rd;
        rd    = '0;
        exp_e = 1'b0;
        if (in_window(a, soc_pkg::RomBase, soc_pkg::RomLength)) begin
            off = a - soc_pkg::RomBase;
            n   = (off >> 3) % soc_pkg::RomWords;
            upper = soc_pkg::RomTag + n;
            if (!is_wr) begin
                rd = {upper, ~upper};
            end
        end else if (in_window(a, soc_pkg::ClintBase, soc_pkg::ClintLength)) begin
            off = (a - soc_pkg::ClintBase) & 32'hFFFF_FFF8;
            if (off == soc_pkg::ClintMsipOffset) begin
                if (is_wr && en[0]) ref_msip = wd[0];
                else if (!is_wr) rd = {63'd0, ref_msip};
            end else if (off == soc_pkg::ClintMtimecmpOffset) begin
                if (is_wr) ref_mtimecmp = apply_bytes(ref_mtimecmp, wd, en);
                else rd = ref_mtimecmp;
            end else if (off == soc_pkg::ClintMtimeOffset) begin
                if (is_wr) ref_mtime = apply_bytes(ref_mtime, wd, en);
                else rd = ref_mtime;
            end
        end else if (in_window(a, soc_pkg::DramBase, soc_pkg::addr_t'(NumWords * 8))) begin
            off = a - soc_pkg::DramBase;
            n   = (off >> 3) % NumWords;
            if (is_wr) ref_mem[n] = apply_bytes(ref_mem[n], wd, en);
            else rd = ref_mem[n];
        end else begin
            exp_e = 1'b1;
        end
        return rd;
    endfunction

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_data(input string name, input soc_pkg::data_t exp_v,
                              input soc_pkg::data_t act_v);
        checks = checks + 1;
        if (act_v !== exp_v) begin
            $display("Fail %s: expected %h, actual %h", name, exp_v, act_v);
            errors = errors + 1;
        end
    endtask

    task automatic check_err(input string name, input logic exp_v, input logic act_v);
        checks = checks + 1;
        if (act_v !== exp_v) begin
            $display("Fail %s err_o: expected %b, actual %b", name, exp_v, act_v);
            errors = errors + 1;
        end
    endtask

    task automatic check_irq(input string name, input logic exp_v, input logic act_v);
        checks = checks + 1;
        if (act_v !== exp_v) begin
            $display("Fail %s: expected %b, actual %b", name, exp_v, act_v);
            errors = errors + 1;
        end
    endtask

    task automatic pop_expected();
        void'(exp_data_q.pop_front());
        void'(exp_err_q.pop_front());
        void'(exp_due_q.pop_front());
        void'(exp_name_q.pop_front());
    endtask

    // Responses are sampled mid-cycle, away from the drive edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (rvalid) begin
                if (exp_data_q.size() == 0) begin
                    $display("Response seen with no request outstanding at cycle %0d", cyc);
                    errors = errors + 1;
                end else begin
                    check_data(exp_name_q[0], exp_data_q[0], rdata);
                    check_err(exp_name_q[0], exp_err_q[0], err);
                    pop_expected();
                end
            end else if (exp_due_q.size() != 0 && exp_due_q[0] <= cyc) begin
                $display("No response arrived for a request of test %s", exp_name_q[0]);
                errors = errors + 1;
                pop_expected();
            end
        end
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic issue(input string name, input logic is_wr, input soc_pkg::addr_t a,
                         input soc_pkg::strb_t en, input soc_pkg::data_t wd);
        soc_pkg::data_t  exp_rd;
        logic            exp_e;
        exp_rd = ref_access(is_wr, a, en, wd, exp_e);
        exp_data_q.push_back(exp_rd);
        exp_err_q.push_back(exp_e);
        exp_due_q.push_back(cyc + 1);
        exp_name_q.push_back(name);
        req   = 1'b1;
        we    = is_wr;
        addr  = a;
        be    = en;
        wdata = wd;
        @(posedge clk);
        #2;
    endtask

    // Idle the bus until all responses are in and the interrupt lines settle
    task automatic settle();
        req = 1'b0;
        @(posedge clk);
        while (exp_data_q.size() != 0) @(posedge clk);
        @(posedge clk);
        #2;
    endtask

    task automatic end_test(input string name);
        req = 1'b0;
        @(posedge clk);
        while (exp_data_q.size() != 0) @(posedge clk);
        #2;
        tests = tests + 1;
        if (errors == test_start_errors) begin
            $display("Test %s: ok", name);
        end else begin
            failed_tests = failed_tests + 1;
            $display("Test %s: %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    task automatic rtc_pulses(input int unsigned k);
        req = 1'b0;
        repeat (k) begin
            rtc = 1'b1;
            repeat (4) @(posedge clk);
            #2;
            rtc = 1'b0;
            repeat (4) @(posedge clk);
            #2;
        end
    endtask

    // DRAM test words spread over the whole depth
    function automatic soc_pkg::addr_t slot_addr(input int unsigned i);
        return soc_pkg::DramBase + soc_pkg::addr_t'(((i * 33) % NumWords) * 8);
    endfunction

    // ----------------------------------------
    // Clock, cycle count and watchdog
    // ----------------------------------------
    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) cyc <= 0;
        else cyc <= cyc + 1;
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("Watchdog expired after %0d cycles", WatchdogCycles);
        $display("Regression failed");
        $finish;
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        void'($urandom(32'h87ea01e9));
        rst_n = 1'b0;
        rtc   = 1'b0;
        req   = 1'b0;
        we    = 1'b0;
        addr  = '0;
        be    = '0;
        wdata = '0;
        checks = 0;
        errors = 0;
        tests  = 0;
        failed_tests      = 0;
        test_start_errors = 0;
        ref_mtime    = '0;
        ref_mtimecmp = '1;
        ref_msip     = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        // ROM contents and a write that must not stick
        for (int n = 0; n < soc_pkg::RomWords; n++) begin
            issue("rom", 1'b0, soc_pkg::RomBase + soc_pkg::addr_t'(n * 8), '0, '0);
        end
        issue("rom", 1'b1, soc_pkg::RomBase + 32'h18, 8'hFF, 64'hDEAD_BEEF_0BAD_F00D);
        issue("rom", 1'b0, soc_pkg::RomBase + 32'h18, '0, '0);
        end_test("rom");

        // Full-word fill, random mix and read back
        for (int i = 0; i < WinWords; i++) begin
            issue("dram", 1'b1, slot_addr(i), 8'hFF, {$urandom, $urandom});
        end
        for (int i = 0; i < MixReqs; i++) begin
            issue("dram", 1'($urandom), slot_addr($urandom % WinWords), 8'($urandom),
                  {$urandom, $urandom});
        end
        for (int i = 0; i < WinWords; i++) begin
            issue("dram", 1'b0, slot_addr(i), '0, '0);
        end
        end_test("dram");

        // Holes in the map and mapped edges
        issue("decode", 1'b0, 32'h0000_0000, '0, '0);
        issue("decode", 1'b1, soc_pkg::RomBase - 32'h8, 8'hFF, 64'h1);
        issue("decode", 1'b0, soc_pkg::RomBase + soc_pkg::RomLength, '0, '0);
        issue("decode", 1'b1, soc_pkg::ClintBase + soc_pkg::ClintLength, 8'hFF, 64'h2);
        issue("decode", 1'b1, soc_pkg::DramBase + soc_pkg::addr_t'(NumWords * 8), 8'hFF, '1);
        issue("decode", 1'b0, 32'hFFFF_FFF8, '0, '0);
        issue("decode", 1'b0, soc_pkg::RomBase + soc_pkg::RomLength - 32'h8, '0, '0);
        issue("decode", 1'b0, soc_pkg::ClintBase + 32'h8, '0, '0);
        issue("decode", 1'b0, slot_addr(0), '0, '0);
        end_test("decode");

        // Earlier ticks are cleared by the mtime write before the counted pulses
        rtc_pulses(PreTicks);
        ref_mtime = ref_mtime + soc_pkg::data_t'(PreTicks);
        issue("mtime", 1'b1, soc_pkg::ClintBase + soc_pkg::ClintMtimeOffset, 8'hFF, '0);
        rtc_pulses(TickCount);
        ref_mtime = ref_mtime + soc_pkg::data_t'(TickCount);
        issue("mtime", 1'b0, soc_pkg::ClintBase + soc_pkg::ClintMtimeOffset, '0, '0);
        end_test("mtime");

        // Timer and software interrupt lines
        issue("irq", 1'b1, soc_pkg::ClintBase + soc_pkg::ClintMtimecmpOffset, 8'hFF, 64'd2);
        settle();
        check_irq("irq timer set", ref_mtime >= ref_mtimecmp, timer_irq);
        issue("irq", 1'b1, soc_pkg::ClintBase + soc_pkg::ClintMtimecmpOffset, 8'hFF, '1);
        settle();
        check_irq("irq timer clear", ref_mtime >= ref_mtimecmp, timer_irq);
        issue("irq", 1'b1, soc_pkg::ClintBase + soc_pkg::ClintMsipOffset, 8'h01, 64'h1);
        settle();
        check_irq("irq ipi set", ref_msip, ipi);
        issue("irq", 1'b1, soc_pkg::ClintBase + soc_pkg::ClintMsipOffset, 8'h01, 64'h0);
        settle();
        check_irq("irq ipi clear", ref_msip, ipi);
        end_test("irq");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
verilog/soc_pkg.sv
verilog/addr_decoder.sv
verilog/boot_rom.sv
verilog/dram_mem.sv
verilog/clint_timer.sv
verilog/soc_harness.sv
verif/tb_soc_harness.sv

/* run.sh */
#!/bin/sh
# Build and run the SoC harness testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_soc_harness \
    -f flist.f \
    -o tb_soc_harness

./obj_dir/tb_soc_harness > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
